//--- vlog.f
+incdir+include
design/noc_dst_pkg.sv
design/tcp_flow_pkg.sv
design/msg_req_mem.sv
design/flow_queue_arb.sv
design/msg_req_meta.sv
design/msg_ptr_poller.sv
design/tcp_msg_poller.sv
verif/tcp_msg_poller_properties.sv
verif/tcp_msg_poller_tb.sv

//--- Makefile
# Verilator flow for the TCP message poller

VERILATOR ?= verilator
FILELIST  ?= vlog.f
TB_TOP    ?= tcp_msg_poller_tb
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= No errors
VFLAGS    ?= --binary --timing --assert -j 0
RUN_ARGS  ?= +verilator+error+limit+1000

SOURCES := $(wildcard design/*.sv verif/*.sv include/*.svh)
SIM_BIN := $(BUILD_DIR)/V$(TB_TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TB_TOP)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(BUILD_DIR)

sim: $(SIM_BIN)
	-./$(SIM_BIN) $(RUN_ARGS) > $(LOG) 2>&1
	cat $(LOG)
	grep -qx "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- verif/tcp_msg_poller_tb.sv
`include "tcp_msg_poller_settings.svh"

module tcp_msg_poller_tb
    import noc_dst_pkg::*;
    import tcp_flow_pkg::*;
();

    localparam int CLK_PERIOD = 40;

    // Cycle budgets per test that the watchdog adds up
    localparam int T1_CYCLES  = 300;
    localparam int T2_CYCLES  = 400;
    localparam int T3_CYCLES  = 600;
    localparam int T4_CYCLES  = 1500;
    localparam int T5_CYCLES  = 600;
    localparam int MARGIN     = 200;
    localparam int RUN_LIMIT  = 3 + T1_CYCLES + T2_CYCLES + T3_CYCLES + T4_CYCLES
                                + T5_CYCLES + MARGIN;

    logic           clk;
    logic           reset;
    logic           req_val;
    logic           req_rdy;
    flowid_t        req_flowid;
    msg_len_t       req_len;
    noc_x_t         req_dst_x;
    noc_y_t         req_dst_y;
    noc_fbits_t     req_dst_fbits;
    logic           meta_val;
    logic           meta_rdy;
    flowid_t        meta_flowid;
    buf_ptr_t       meta_ptr;
    msg_len_t       meta_len;
    noc_x_t         meta_dst_x;
    noc_y_t         meta_dst_y;
    noc_fbits_t     meta_dst_fbits;
    logic           ptr_rd_req_val;
    flowid_t        ptr_rd_req_flowid;
    logic           ptr_rd_resp_val;
    buf_ptr_t       ptr_rd_resp_base;
    buf_ptr_t       ptr_rd_resp_end;

    // Pointer table model
    buf_ptr_t       base_ptr [`MAX_FLOW_CNT];
    buf_ptr_t       end_ptr  [`MAX_FLOW_CNT];

    // Scoreboard with one open request per flow
    logic [`MAX_FLOW_CNT-1:0] pending;
    msg_len_t       exp_len   [`MAX_FLOW_CNT];
    noc_x_t         exp_x     [`MAX_FLOW_CNT];
    noc_y_t         exp_y     [`MAX_FLOW_CNT];
    noc_fbits_t     exp_fbits [`MAX_FLOW_CNT];

    logic [31:0]    rng_state = 32'h45621592;
    logic           rdy_random;
    int             error_cnt;
    int             check_cnt;
    int             desc_cnt;

    tcp_msg_poller #(
         .CHK_SPACE_EMPTY   (0)
    ) tcp_msg_poller_inst (
         .clk               (clk              )
        ,.reset             (reset            )
        ,.req_val           (req_val          )
        ,.req_rdy           (req_rdy          )
        ,.req_flowid        (req_flowid       )
        ,.req_len           (req_len          )
        ,.req_dst_x         (req_dst_x        )
        ,.req_dst_y         (req_dst_y        )
        ,.req_dst_fbits     (req_dst_fbits    )
        ,.meta_val          (meta_val         )
        ,.meta_rdy          (meta_rdy         )
        ,.meta_flowid       (meta_flowid      )
        ,.meta_ptr          (meta_ptr         )
        ,.meta_len          (meta_len         )
        ,.meta_dst_x        (meta_dst_x       )
        ,.meta_dst_y        (meta_dst_y       )
        ,.meta_dst_fbits    (meta_dst_fbits   )
        ,.ptr_rd_req_val    (ptr_rd_req_val   )
        ,.ptr_rd_req_flowid (ptr_rd_req_flowid)
        ,.ptr_rd_resp_val   (ptr_rd_resp_val  )
        ,.ptr_rd_resp_base  (ptr_rd_resp_base )
        ,.ptr_rd_resp_end   (ptr_rd_resp_end  )
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function int total_errors();
        return error_cnt + tcp_msg_poller_inst.poller_props.fail_cnt;
    endfunction

    task automatic log_mismatch(input string msg);
        $display("** Error at %0t: %s", $time, msg);
        error_cnt++;
    endtask

    // Advance to the drive point after the n-th rising edge
    task automatic step(input int n);
        repeat (n) @(posedge clk);
        #5;
    endtask

    task automatic set_flow_ptrs(input flowid_t f, input buf_ptr_t base, input buf_ptr_t fill);
        base_ptr[f] = base;
        end_ptr[f]  = base + fill; // Wraps modulo the pointer width
    endtask

    task automatic send_req(input flowid_t f, input msg_len_t len);
        logic [31:0] r;
        r            = next_rand();
        exp_len[f]   = len;
        exp_x[f]     = r[7:0];
        exp_y[f]     = r[15:8];
        exp_fbits[f] = r[19:16];
        pending[f]   = 1'b1;
        req_val       = 1'b1;
        req_flowid    = f;
        req_len       = len;
        req_dst_x     = r[7:0];
        req_dst_y     = r[15:8];
        req_dst_fbits = r[19:16];
        @(negedge clk);
        while (!req_rdy) begin
            @(negedge clk);
        end
        step(1);
        req_val = 1'b0;
    endtask

    task automatic wait_flows_done(input int limit);
        int cycles;
        cycles = 0;
        while (pending != '0 && cycles < limit) begin
            step(1);
            cycles++;
        end
        for (int f = 0; f < `MAX_FLOW_CNT; f++) begin
            if (pending[f]) begin
                $display("Flow %0d still has no descriptor after %0d cycles", f, limit);
                error_cnt++;
            end
        end
    endtask

    task automatic report_test(input int num, input string name, input int desc0, input int err0);
        $display("Test %0d (%s) finished: %0d descriptors, %0d errors",
                 num, name, desc_cnt - desc0, total_errors() - err0);
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin : ptr_table_model
        flowid_t rd_flow;
        int      lat;
        forever begin
            @(negedge clk);
            if (!reset && ptr_rd_req_val) begin
                rd_flow = ptr_rd_req_flowid;
                lat     = 1 + int'(next_rand() % 4);
                repeat (lat) @(posedge clk);
                #5;
                ptr_rd_resp_val  = 1'b1;
                ptr_rd_resp_base = base_ptr[rd_flow];
                ptr_rd_resp_end  = end_ptr[rd_flow];
                step(1);
                ptr_rd_resp_val  = 1'b0;
            end
        end
    end

    initial begin : meta_rdy_driver
        logic [31:0] r;
        int          hold;
        hold = 0;
        forever begin
            step(1);
            if (!rdy_random) begin
                meta_rdy = 1'b1;
                hold     = 0;
            end else begin
                if (hold == 0) begin
                    r        = next_rand();
                    meta_rdy = r[0];
                    hold     = 1 + int'(r[3:1]); // Stretch of 1 to 8 cycles
                end
                hold--;
            end
        end
    end

    // Handshake seen mid-cycle completes on the next rising edge
    always @(negedge clk) begin : descriptor_monitor
        flowid_t  f;
        buf_ptr_t occ;
        if (!reset && meta_val && meta_rdy) begin
            f   = meta_flowid;
            occ = end_ptr[f] - base_ptr[f];
            check_cnt += 5;
            assert (pending[f])
                else log_mismatch($sformatf("descriptor for flow %0d with no open request", f));
            assert (meta_len == exp_len[f])
                else log_mismatch($sformatf("flow %0d length %0h, expected %0h",
                                            f, meta_len, exp_len[f]));
            assert ({meta_dst_x, meta_dst_y, meta_dst_fbits}
                    == {exp_x[f], exp_y[f], exp_fbits[f]})
                else log_mismatch($sformatf("flow %0d destination mismatch", f));
            assert (meta_ptr == base_ptr[f])
                else log_mismatch($sformatf("flow %0d pointer %0h, expected %0h",
                                            f, meta_ptr, base_ptr[f]));
            assert (occ >= {1'b0, exp_len[f]})
                else log_mismatch($sformatf("flow %0d emitted with only %0h bytes", f, occ));
            pending[f] = 1'b0;
            desc_cnt++;
        end
    end

    initial begin : watchdog
        repeat (RUN_LIMIT) @(posedge clk);
        $display("Run timed out after %0d cycles", RUN_LIMIT);
        $display("Errors found");
        $finish;
    end

    initial begin
        logic [31:0] r;
        msg_len_t    len;
        int          fill;
        int          desc0;
        int          err0;
        reset            = 1'b1;
        req_val          = 1'b0;
        req_flowid       = '0;
        req_len          = '0;
        req_dst_x        = '0;
        req_dst_y        = '0;
        req_dst_fbits    = '0;
        meta_rdy         = 1'b0;
        ptr_rd_resp_val  = 1'b0;
        ptr_rd_resp_base = '0;
        ptr_rd_resp_end  = '0;
        rdy_random       = 1'b0;
        pending          = '0;
        error_cnt        = 0;
        check_cnt        = 0;
        desc_cnt         = 0;
        for (int f = 0; f < `MAX_FLOW_CNT; f++) begin
            base_ptr[f] = '0;
            end_ptr[f]  = '0;
        end
        step(3);
        reset = 1'b0;

        desc0 = desc_cnt;
        err0  = total_errors();
        set_flow_ptrs(3, 9'h010, 9'h040);
        send_req(3, 8'h30);
        set_flow_ptrs(5, 9'h1F0, 9'h030); // End lands at 0x020 with exactly enough data
        send_req(5, 8'h30);
        wait_flows_done(T1_CYCLES);
        report_test(1, "ready flows, wrapped pointers", desc0, err0);

        desc0 = desc_cnt;
        err0  = total_errors();
        set_flow_ptrs(7, 9'h080, 9'h010);
        send_req(7, 8'h40);
        step(40);
        assert (pending[7])
            else log_mismatch("flow 7 answered before its data arrived");
        end_ptr[7] = end_ptr[7] + 9'h030;
        wait_flows_done(T2_CYCLES);
        report_test(2, "short flow until end advances", desc0, err0);

        desc0 = desc_cnt;
        err0  = total_errors();
        for (int i = 8; i < 16; i++) begin
            r    = next_rand();
            len  = r[7:0];
            fill = int'(len) + int'(r[15:8]) % (257 - int'(len));
            set_flow_ptrs(flowid_t'(i), buf_ptr_t'(r[31:23]), buf_ptr_t'(fill));
            send_req(flowid_t'(i), len);
        end
        wait_flows_done(T3_CYCLES);
        report_test(3, "eight random flows", desc0, err0);

        desc0      = desc_cnt;
        err0       = total_errors();
        rdy_random = 1'b1;
        for (int i = 0; i < 8; i++) begin
            r    = next_rand();
            len  = (r[7:0] & 8'h7F) | 8'h01;
            fill = (i % 2 == 1) ? int'(len) / 2 : int'(len) + int'(r[11:8]);
            set_flow_ptrs(flowid_t'(i), buf_ptr_t'(r[31:23]), buf_ptr_t'(fill));
            send_req(flowid_t'(i), len);
        end
        step(20);
        for (int i = 1; i < 8; i += 2) begin
            end_ptr[i] = base_ptr[i] + buf_ptr_t'(exp_len[i]); // Odd flows now just enough
        end
        wait_flows_done(T4_CYCLES);
        rdy_random = 1'b0;
        report_test(4, "random meta_rdy stalls", desc0, err0);

        desc0 = desc_cnt;
        err0  = total_errors();
        set_flow_ptrs(12, 9'h0F8, 9'h020);
        send_req(12, 8'h20);
        wait_flows_done(T5_CYCLES / 2);
        set_flow_ptrs(12, 9'h0F8, 9'h090);
        send_req(12, 8'h80);
        wait_flows_done(T5_CYCLES / 2);
        report_test(5, "re-request after descriptor", desc0, err0);

        $display("Tests: 5, descriptors: %0d, checks: %0d, errors: %0d, assertion failures: %0d",
                 desc_cnt, check_cnt, error_cnt, tcp_msg_poller_inst.poller_props.fail_cnt);
        if (total_errors() == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- verif/tcp_msg_poller_properties.sv
module tcp_msg_poller_properties
    import noc_dst_pkg::*;
    import tcp_flow_pkg::*;
(
     input  logic           clk
    ,input  logic           reset

    ,input  logic           req_rdy
    ,input  logic           meta_val
    ,input  logic           meta_rdy
    ,input  flowid_t        meta_flowid
    ,input  buf_ptr_t       meta_ptr
    ,input  msg_len_t       meta_len
    ,input  noc_x_t         meta_dst_x
    ,input  noc_y_t         meta_dst_y
    ,input  noc_fbits_t     meta_dst_fbits

    ,input  logic           ptr_rd_req_val
    ,input  logic           ptr_rd_resp_val

    ,input  logic           pop
    ,input  logic           mem_rd_val
    ,input  logic           poll_push_val
    ,input  logic           active_clr_val
);

    int     fail_cnt = 0;
    logic   rd_pending; // Pointer read issued and no response yet

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_pending <= 1'b0;
        end else if (ptr_rd_req_val) begin
            rd_pending <= 1'b1;
        end else if (ptr_rd_resp_val) begin
            rd_pending <= 1'b0;
        end
    end

    rdy_low_in_reset: assert property (@(posedge clk) reset |-> !req_rdy)
        else begin
            $error("req_rdy high while reset is asserted");
            fail_cnt++;
        end

    // One cycle after a reset edge every internal strobe must be quiet
    ctrl_quiet_after_reset: assert property (@(posedge clk) $past(reset) |->
        !(meta_val || ptr_rd_req_val || pop || mem_rd_val || poll_push_val || active_clr_val))
        else begin
            $error("control strobe active right after reset");
            fail_cnt++;
        end

    meta_held_while_stalled: assert property (@(posedge clk) disable iff (reset)
        meta_val && !meta_rdy |=> meta_val && $stable(meta_flowid) && $stable(meta_ptr)
            && $stable(meta_len) && $stable(meta_dst_x) && $stable(meta_dst_y)
            && $stable(meta_dst_fbits))
        else begin
            $error("descriptor dropped or changed while meta_rdy low");
            fail_cnt++;
        end

    one_ptr_read: assert property (@(posedge clk) disable iff (reset)
        rd_pending |-> !ptr_rd_req_val)
        else begin
            $error("second pointer read before the response");
            fail_cnt++;
        end

endmodule

bind tcp_msg_poller tcp_msg_poller_properties poller_props (
     .clk               (clk            )
    ,.reset             (reset          )
    ,.req_rdy           (req_rdy        )
    ,.meta_val          (meta_val       )
    ,.meta_rdy          (meta_rdy       )
    ,.meta_flowid       (meta_flowid    )
    ,.meta_ptr          (meta_ptr       )
    ,.meta_len          (meta_len       )
    ,.meta_dst_x        (meta_dst_x     )
    ,.meta_dst_y        (meta_dst_y     )
    ,.meta_dst_fbits    (meta_dst_fbits )
    ,.ptr_rd_req_val    (ptr_rd_req_val )
    ,.ptr_rd_resp_val   (ptr_rd_resp_val)
    ,.pop               (pop            )
    ,.mem_rd_val        (mem_rd_val     )
    ,.poll_push_val     (poll_push_val  )
    ,.active_clr_val    (active_clr_val )
);

//--- design/tcp_msg_poller.sv
`include "tcp_msg_poller_settings.svh"

module tcp_msg_poller
    import noc_dst_pkg::*;
    import tcp_flow_pkg::*;
#(
     parameter int CHK_SPACE_EMPTY = 0
)(
     input  logic           clk
    ,input  logic           reset

    ,input  logic           req_val
    ,output logic           req_rdy
    ,input  flowid_t        req_flowid
    ,input  msg_len_t       req_len
    ,input  noc_x_t         req_dst_x
    ,input  noc_y_t         req_dst_y
    ,input  noc_fbits_t     req_dst_fbits

    ,output logic           meta_val
    ,input  logic           meta_rdy
    ,output flowid_t        meta_flowid
    ,output buf_ptr_t       meta_ptr
    ,output msg_len_t       meta_len
    ,output noc_x_t         meta_dst_x
    ,output noc_y_t         meta_dst_y
    ,output noc_fbits_t     meta_dst_fbits

    ,output logic           ptr_rd_req_val
    ,output flowid_t        ptr_rd_req_flowid
    ,input  logic           ptr_rd_resp_val
    ,input  buf_ptr_t       ptr_rd_resp_base
    ,input  buf_ptr_t       ptr_rd_resp_end
);

    logic               mem_wr_val;
    flowid_t            mem_wr_addr;
    msg_req_entry_t     mem_wr_data;

    logic               meta_push_val;
    flowid_t            meta_push_flowid;

    logic               active_clr_val;
    flowid_t            active_clr_flowid;

    logic               pop;
    logic               q_empty;
    flowid_t            q_flowid;

    logic               poll_push_val;
    flowid_t            poll_push_flowid;
    logic               poll_push_grant;

    logic               mem_rd_val;
    flowid_t            mem_rd_addr;
    msg_req_entry_t     mem_rd_data;

    msg_req_meta metadata_handler (
         .clk               (clk                )
        ,.reset             (reset              )
        ,.req_val           (req_val            )
        ,.req_flowid        (req_flowid         )
        ,.req_len           (req_len            )
        ,.req_dst_x         (req_dst_x          )
        ,.req_dst_y         (req_dst_y          )
        ,.req_dst_fbits     (req_dst_fbits      )
        ,.req_rdy           (req_rdy            )
        ,.mem_wr_val        (mem_wr_val         )
        ,.mem_wr_addr       (mem_wr_addr        )
        ,.mem_wr_data       (mem_wr_data        )
        ,.meta_push_val     (meta_push_val      )
        ,.meta_push_flowid  (meta_push_flowid   )
        ,.active_clr_val    (active_clr_val     )
        ,.active_clr_flowid (active_clr_flowid  )
    );

    // Request kept outside the queue so it can be updated in place
    msg_req_mem req_mem (
         .clk       (clk        )
        ,.wr_val    (mem_wr_val )
        ,.wr_addr   (mem_wr_addr)
        ,.wr_data   (mem_wr_data)
        ,.rd_val    (mem_rd_val )
        ,.rd_addr   (mem_rd_addr)
        ,.rd_data   (mem_rd_data)
    );

    flow_queue_arb req_q (
         .clk               (clk                )
        ,.reset             (reset              )
        ,.meta_push_val     (meta_push_val      )
        ,.meta_push_flowid  (meta_push_flowid   )
        ,.poll_push_val     (poll_push_val      )
        ,.poll_push_flowid  (poll_push_flowid   )
        ,.poll_push_grant   (poll_push_grant    )
        ,.pop               (pop                )
        ,.q_empty           (q_empty            )
        ,.q_flowid          (q_flowid           )
    );

    msg_ptr_poller #(
         .CHK_SPACE_EMPTY   (CHK_SPACE_EMPTY)
    ) ptr_poller (
         .clk               (clk                )
        ,.reset             (reset              )
        ,.q_empty           (q_empty            )
        ,.q_flowid          (q_flowid           )
        ,.pop               (pop                )
        ,.poll_push_val     (poll_push_val      )
        ,.poll_push_flowid  (poll_push_flowid   )
        ,.poll_push_grant   (poll_push_grant    )
        ,.mem_rd_val        (mem_rd_val         )
        ,.mem_rd_addr       (mem_rd_addr        )
        ,.mem_rd_data       (mem_rd_data        )
        ,.ptr_rd_req_val    (ptr_rd_req_val     )
        ,.ptr_rd_req_flowid (ptr_rd_req_flowid  )
        ,.ptr_rd_resp_val   (ptr_rd_resp_val    )
        ,.ptr_rd_resp_base  (ptr_rd_resp_base   )
        ,.ptr_rd_resp_end   (ptr_rd_resp_end    )
        ,.active_clr_val    (active_clr_val     )
        ,.active_clr_flowid (active_clr_flowid  )
        ,.meta_val          (meta_val           )
        ,.meta_flowid       (meta_flowid        )
        ,.meta_ptr          (meta_ptr           )
        ,.meta_len          (meta_len           )
        ,.meta_dst_x        (meta_dst_x         )
        ,.meta_dst_y        (meta_dst_y         )
        ,.meta_dst_fbits    (meta_dst_fbits     )
        ,.meta_rdy          (meta_rdy           )
    );

endmodule

//--- design/msg_ptr_poller.sv
`include "tcp_msg_poller_settings.svh"

module msg_ptr_poller
    import noc_dst_pkg::*;
    import tcp_flow_pkg::*;
#(
     parameter int CHK_SPACE_EMPTY = 0
)(
     input  logic               clk
    ,input  logic               reset

    ,input  logic               q_empty
    ,input  flowid_t            q_flowid
    ,output logic               pop

    ,output logic               poll_push_val
    ,output flowid_t            poll_push_flowid
    ,input  logic               poll_push_grant

    ,output logic               mem_rd_val
    ,output flowid_t            mem_rd_addr
    ,input  msg_req_entry_t     mem_rd_data

    ,output logic               ptr_rd_req_val
    ,output flowid_t            ptr_rd_req_flowid
    ,input  logic               ptr_rd_resp_val
    ,input  buf_ptr_t           ptr_rd_resp_base
    ,input  buf_ptr_t           ptr_rd_resp_end

    ,output logic               active_clr_val
    ,output flowid_t            active_clr_flowid

    ,output logic               meta_val
    ,output flowid_t            meta_flowid
    ,output buf_ptr_t           meta_ptr
    ,output msg_len_t           meta_len
    ,output noc_x_t             meta_dst_x
    ,output noc_y_t             meta_dst_y
    ,output noc_fbits_t         meta_dst_fbits
    ,input  logic               meta_rdy
);

    localparam buf_ptr_t BUF_SIZE = buf_ptr_t'(1) << `POLLER_PTR_W;

    typedef enum logic [2:0] {
        st_idle,
        st_fetch,
        st_wait,
        st_emit,
        st_requeue
    } poll_state_e;

    poll_state_e        state;
    poll_state_e        state_next;

    flowid_t            flowid_r;
    msg_req_entry_t     req_r;
    buf_ptr_t           base_r;
    buf_ptr_t           end_r;
    logic               ptr_got;

    buf_ptr_t           occupancy;
    buf_ptr_t           avail;
    logic               flow_ready;

    // Difference wraps naturally thanks to the extra pointer bit
    assign occupancy  = end_r - base_r;
    assign avail      = (CHK_SPACE_EMPTY != 0) ? BUF_SIZE - occupancy : occupancy;
    assign flow_ready = avail >= {1'b0, req_r.len};

    // Both reads go out with the pop
    assign mem_rd_addr       = q_flowid;
    assign ptr_rd_req_flowid = q_flowid;

    assign poll_push_flowid  = flowid_r;
    assign active_clr_flowid = flowid_r;

    assign meta_flowid    = flowid_r;
    assign meta_ptr       = (CHK_SPACE_EMPTY != 0) ? end_r : base_r;
    assign meta_len       = req_r.len;
    assign meta_dst_x     = req_r.dst_x;
    assign meta_dst_y     = req_r.dst_y;
    assign meta_dst_fbits = req_r.dst_fbits;

    always_comb begin
        state_next     = state;
        pop            = 1'b0;
        mem_rd_val     = 1'b0;
        ptr_rd_req_val = 1'b0;
        poll_push_val  = 1'b0;
        active_clr_val = 1'b0;
        meta_val       = 1'b0;
        case (state)
            st_idle: begin
                if (!q_empty) begin
                    pop            = 1'b1;
                    mem_rd_val     = 1'b1;
                    ptr_rd_req_val = 1'b1;
                    state_next     = st_fetch;
                end
            end
            st_fetch: state_next = st_wait; // Memory data lands here
            st_wait: begin
                if (ptr_got) begin
                    state_next = flow_ready ? st_emit : st_requeue;
                end
            end
            st_emit: begin
                meta_val = 1'b1;
                if (meta_rdy) begin
                    active_clr_val = 1'b1;
                    state_next     = st_idle;
                end
            end
            st_requeue: begin
                poll_push_val = 1'b1;
                if (poll_push_grant) begin
                    state_next = st_idle;
                end
            end
            default: state_next = st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= st_idle;
            ptr_got <= 1'b0;
        end else begin
            state <= state_next;
            if (state == st_idle) begin
                ptr_got <= 1'b0;
            end else if (ptr_rd_resp_val) begin
                ptr_got <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            flowid_r <= q_flowid;
        end
        if (state == st_fetch) begin
            req_r <= mem_rd_data;
        end
        if (ptr_rd_resp_val) begin
            base_r <= ptr_rd_resp_base;
            end_r  <= ptr_rd_resp_end;
        end
    end

endmodule

//--- design/msg_req_meta.sv
`include "tcp_msg_poller_settings.svh"

module msg_req_meta
    import noc_dst_pkg::*;
    import tcp_flow_pkg::*;
(
     input  logic               clk
    ,input  logic               reset

    ,input  logic               req_val
    ,input  flowid_t            req_flowid
    ,input  msg_len_t           req_len
    ,input  noc_x_t             req_dst_x
    ,input  noc_y_t             req_dst_y
    ,input  noc_fbits_t         req_dst_fbits
    ,output logic               req_rdy

    ,output logic               mem_wr_val
    ,output flowid_t            mem_wr_addr
    ,output msg_req_entry_t     mem_wr_data

    ,output logic               meta_push_val
    ,output flowid_t            meta_push_flowid

    ,input  logic               active_clr_val
    ,input  flowid_t            active_clr_flowid
);

    // Flows with a request outstanding
    logic [`MAX_FLOW_CNT-1:0]   active_bitvec;

    logic                       req_fire;
    logic                       clr_hit;

    assign req_rdy  = ~reset;
    assign req_fire = req_val & req_rdy;

    // Poller is retiring this same flow right now
    assign clr_hit = active_clr_val & (active_clr_flowid == req_flowid);

    assign mem_wr_val  = req_fire;
    assign mem_wr_addr = req_flowid;

    always_comb begin
        mem_wr_data.len       = req_len;
        mem_wr_data.dst_x     = req_dst_x;
        mem_wr_data.dst_y     = req_dst_y;
        mem_wr_data.dst_fbits = req_dst_fbits;
    end

    // Enqueue only flows that are not already queued or being polled.
    // A flow being cleared this cycle counts as inactive, else the request is lost
    assign meta_push_val    = req_fire & (~active_bitvec[req_flowid] | clr_hit);
    assign meta_push_flowid = req_flowid;

    always_ff @(posedge clk) begin
        if (reset) begin
            active_bitvec <= '0;
        end else begin
            if (active_clr_val) begin
                active_bitvec[active_clr_flowid] <= 1'b0;
            end
            if (req_fire) begin
                active_bitvec[req_flowid] <= 1'b1; // Set wins over clear
            end
        end
    end

endmodule

//--- design/flow_queue_arb.sv
`include "tcp_msg_poller_settings.svh"

module flow_queue_arb import tcp_flow_pkg::*; (
     input  logic       clk
    ,input  logic       reset

    ,input  logic       meta_push_val
    ,input  flowid_t    meta_push_flowid

    ,input  logic       poll_push_val
    ,input  flowid_t    poll_push_flowid
    ,output logic       poll_push_grant

    ,input  logic       pop
    ,output logic       q_empty
    ,output flowid_t    q_flowid
);

    localparam int DEPTH = `FLOW_Q_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    flowid_t            q_mem [DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [PTR_W:0]     count;

    logic               push;
    flowid_t            push_flowid;

    // Handler has fixed priority, poller only writes when handler is quiet
    assign poll_push_grant = ~meta_push_val;
    assign push            = meta_push_val | poll_push_val;
    assign push_flowid     = meta_push_val ? meta_push_flowid : poll_push_flowid;

    assign q_empty  = (count == '0);
    assign q_flowid = q_mem[rd_ptr]; // Head visible without a pop

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // Idle or push and pop together
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            q_mem[wr_ptr] <= push_flowid;
        end
    end

endmodule

//--- design/msg_req_mem.sv
`include "tcp_msg_poller_settings.svh"

module msg_req_mem import tcp_flow_pkg::*; (
     input  logic               clk

    ,input  logic               wr_val
    ,input  flowid_t            wr_addr
    ,input  msg_req_entry_t     wr_data

    ,input  logic               rd_val
    ,input  flowid_t            rd_addr
    ,output msg_req_entry_t     rd_data
);

    // One entry per flow, rewritten in place on a new request
    msg_req_entry_t mem [`MAX_FLOW_CNT];

    always_ff @(posedge clk) begin
        if (wr_val) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Registered read, same-address write shows up one read later
    always_ff @(posedge clk) begin
        if (rd_val) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

//--- design/tcp_flow_pkg.sv
`include "tcp_msg_poller_settings.svh"

package tcp_flow_pkg;
    import noc_dst_pkg::*;

    typedef logic [`FLOWID_W-1:0]     flowid_t;

    // Requested byte count
    typedef logic [`POLLER_PTR_W-1:0] msg_len_t;

    // Buffer pointer with wrap bit on top
    typedef logic [`POLLER_PTR_W:0]   buf_ptr_t;

    // One stored request per flow
    typedef struct packed {
        msg_len_t   len;
        noc_x_t     dst_x;
        noc_y_t     dst_y;
        noc_fbits_t dst_fbits;
    } msg_req_entry_t;

endpackage

//--- design/noc_dst_pkg.sv
`include "tcp_msg_poller_settings.svh"

package noc_dst_pkg;

    // Tile coordinates
    typedef logic [`NOC_X_W-1:0]     noc_x_t;
    typedef logic [`NOC_Y_W-1:0]     noc_y_t;

    // Port select on the last hop
    typedef logic [`NOC_FBITS_W-1:0] noc_fbits_t;

endpackage

//--- include/tcp_msg_poller_settings.svh
`ifndef TCP_MSG_POLLER_SETTINGS_SVH
`define TCP_MSG_POLLER_SETTINGS_SVH

// Flow table size
`define MAX_FLOW_CNT    16
`define FLOWID_W        $clog2(`MAX_FLOW_CNT)

// log2 of the buffer size, pointers carry one extra wrap bit
`define POLLER_PTR_W    8

// NoC destination fields
`define NOC_X_W         8
`define NOC_Y_W         8
`define NOC_FBITS_W     4

// Every flow can sit in the queue at most once
`define FLOW_Q_DEPTH    `MAX_FLOW_CNT

`endif
